//--- rtl/l2_cache_pkg.sv
// Line constants, request opcodes and the request, lookup, update and response structs.
`default_nettype none

package l2_cache_pkg;
	// Line geometry and line address width.
	localparam int LINE_BYTES = 16;
	localparam int LINE_BITS = LINE_BYTES * 8;
	localparam int ADDR_WIDTH = 26;

	typedef enum logic [1:0] {
		OP_LOAD,
		OP_STORE,
		OP_LOAD_SYNC,
		OP_STORE_SYNC
	} l2_op_t;

	// Request as it travels down the pipeline.
	typedef struct packed {
		logic valid;
		logic [1:0] unit;
		logic [1:0] strand;
		l2_op_t op;
		logic [ADDR_WIDTH-1:0] address;
		logic [LINE_BITS-1:0] data;
		logic [LINE_BYTES-1:0] mask;
		logic has_sm_data;
		logic [LINE_BITS-1:0] sm_data;
	} l2_req_t;

	// Result of one way for the set indexed by the tag stage.
	typedef struct packed {
		logic hit;
		logic [LINE_BITS-1:0] data;
	} l2_lookup_t;

	// Array write; tag holds the whole line address, each way slices out its tag bits.
	typedef struct packed {
		logic valid;
		logic [7:0] way;
		logic [7:0] set;
		logic [ADDR_WIDTH-1:0] tag;
		logic [LINE_BITS-1:0] data;
	} l2_update_t;

	typedef struct packed {
		logic valid;
		logic [1:0] unit;
		logic [1:0] strand;
		l2_op_t op;
		logic [ADDR_WIDTH-1:0] address;
		logic [LINE_BITS-1:0] data;
		logic hit;
		logic sync_success;
	} l2_resp_t;
endpackage

`default_nettype wire

//--- rtl/l2_cache_tag.sv
// Tag issue stage: request register that feeds the lookup of every way.
`default_nettype none

module l2_cache_tag (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_req_t req,
	output l2_cache_pkg::l2_req_t tag_req
);
	import l2_cache_pkg::*;

	l2_req_t req_clean;

	// An idle slot carries no store mask and no memory data.
	always_comb
	begin
		req_clean = req;
		if (!req.valid)
		begin
			req_clean.mask = '0;
			req_clean.sm_data = '0;
			req_clean.has_sm_data = 1'b0;
		end
	end

	// Only the valid flag is cleared on reset.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tag_req.valid <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			tag_req <= req_clean;
		end
	end
endmodule

`default_nettype wire

//--- rtl/l2_cache_way.sv
// One cache way: valid bits, tags and line data per set, combinational lookup, synchronous write.
`default_nettype none

module l2_cache_way #(
	parameter int NUM_SETS = 16,
	parameter int WAY_ID = 0
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_req_t tag_req,
	input wire l2_cache_pkg::l2_update_t update,
	output l2_cache_pkg::l2_lookup_t lookup
);
	import l2_cache_pkg::*;

	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS;
	localparam logic [7:0] WAY_SEL = 8'(WAY_ID);

	logic [NUM_SETS-1:0] valid_bits;
	logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
	logic [LINE_BITS-1:0] data_mem [NUM_SETS];

	logic [SET_BITS-1:0] req_set;
	logic [TAG_BITS-1:0] req_tag;
	logic [SET_BITS-1:0] upd_set;
	logic [TAG_BITS-1:0] upd_tag;
	logic write_en;

	assign req_set = tag_req.address[SET_BITS-1:0];
	assign req_tag = tag_req.address[ADDR_WIDTH-1:SET_BITS];

	// Lookup for the request now in the tag register.
	always_comb
	begin
		lookup.hit = tag_req.valid && valid_bits[req_set] && tag_mem[req_set] == req_tag;
		lookup.data = data_mem[req_set];
	end

	assign upd_set = update.set[SET_BITS-1:0];
	assign upd_tag = update.tag[ADDR_WIDTH-1:SET_BITS];

	// Only the way named in the update takes it.
	assign write_en = update.valid && update.way == WAY_SEL && !stall_pipeline;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
		end
		else if (write_en)
		begin
			valid_bits[upd_set] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			tag_mem[upd_set] <= upd_tag;
			data_mem[upd_set] <= update.data;
		end
	end
endmodule

`default_nettype wire

//--- rtl/l2_cache_read.sv
// Read stage: hit and victim way selection, update forwarding and store-sync link tracking.
`default_nettype none

module l2_cache_read #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_SETS = 16,
	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_req_t tag_req,
	input wire l2_cache_pkg::l2_lookup_t [NUM_WAYS-1:0] lookup,
	input wire l2_cache_pkg::l2_update_t update,
	output l2_cache_pkg::l2_req_t rd_req,
	output logic [l2_cache_pkg::LINE_BITS-1:0] rd_old_data,
	output logic rd_hit,
	output logic [WAY_BITS-1:0] rd_way,
	output logic rd_sync_success
);
	import l2_cache_pkg::*;

	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int NUM_STRANDS = 4;

	logic [SET_BITS-1:0] req_set;
	logic upd_same_set;
	logic fwd_hit;
	logic [NUM_WAYS-1:0] way_hit;
	logic hit_any;
	logic [WAY_BITS-1:0] hit_way;
	logic [LINE_BITS-1:0] hit_data;
	logic [NUM_SETS-1:0][WAY_BITS-1:0] rr_count;
	logic [NUM_STRANDS-1:0] link_valid;
	logic [NUM_STRANDS-1:0][ADDR_WIDTH-1:0] link_addr;
	logic sync_ok;
	logic store_commit;
	logic fill;

	assign req_set = tag_req.address[SET_BITS-1:0];
	assign upd_same_set = update.valid && update.set == 8'(req_set);
	assign fwd_hit = tag_req.valid && upd_same_set && update.tag == tag_req.address;

	always_comb
	begin
		hit_any = 1'b0;
		hit_way = '0;
		hit_data = '0;
		for (int i = 0; i < NUM_WAYS; i++)
		begin
			// A way being rewritten in this set no longer holds what it reports.
			way_hit[i] = lookup[i].hit && !(upd_same_set && update.way == 8'(i));
			if (way_hit[i])
			begin
				hit_any = 1'b1;
				hit_way = hit_way | WAY_BITS'(i);
				hit_data = hit_data | lookup[i].data;
			end
		end
		// The in-flight write wins over the array contents.
		if (fwd_hit)
		begin
			hit_any = 1'b1;
			hit_way = WAY_BITS'(update.way);
			hit_data = update.data;
		end
	end

	// Success is only reported for a store-sync whose strand still holds the link.
	assign sync_ok = tag_req.valid && tag_req.op == OP_STORE_SYNC
		&& link_valid[tag_req.strand] && link_addr[tag_req.strand] == tag_req.address;

	// A store that really writes the line breaks every link on it.
	assign store_commit = tag_req.valid && (hit_any || tag_req.has_sm_data)
		&& (tag_req.op == OP_STORE || sync_ok);

	assign fill = tag_req.valid && tag_req.has_sm_data && !hit_any;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_req.valid <= 1'b0;
			rd_hit <= 1'b0;
			rd_sync_success <= 1'b0;
			rr_count <= '0;
			link_valid <= '0;
			link_addr <= '0;
		end
		else if (!stall_pipeline)
		begin
			rd_req <= tag_req;
			rd_hit <= hit_any;
			rd_way <= hit_any ? hit_way : rr_count[req_set];
			rd_old_data <= hit_data;
			rd_sync_success <= sync_ok;
			if (fill)
			begin
				if (rr_count[req_set] == WAY_BITS'(NUM_WAYS - 1))
					rr_count[req_set] <= '0;
				else
					rr_count[req_set] <= rr_count[req_set] + 1'b1;
			end
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (store_commit && link_addr[s] == tag_req.address)
					link_valid[s] <= 1'b0;
			end
			if (tag_req.valid && tag_req.op == OP_LOAD_SYNC)
			begin
				link_valid[tag_req.strand] <= 1'b1;
				link_addr[tag_req.strand] <= tag_req.address;
			end
		end
	end
endmodule

`default_nettype wire

//--- rtl/l2_cache_write.sv
// Write stage: byte-mask store merge, response register and the array update.
`default_nettype none

module l2_cache_write #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_SETS = 16,
	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_req_t rd_req,
	input wire logic [l2_cache_pkg::LINE_BITS-1:0] rd_old_data,
	input wire logic rd_hit,
	input wire logic [WAY_BITS-1:0] rd_way,
	input wire logic rd_sync_success,
	output l2_cache_pkg::l2_update_t update,
	output l2_cache_pkg::l2_resp_t resp
);
	import l2_cache_pkg::*;

	localparam int SET_BITS = $clog2(NUM_SETS);

	logic [LINE_BITS-1:0] old_line;
	logic [LINE_BITS-1:0] merged_line;
	logic is_store;
	logic line_present;

	// Memory data replaces whatever the read stage found.
	assign old_line = rd_req.has_sm_data ? rd_req.sm_data : rd_old_data;

	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
		begin
			if (rd_req.mask[b])
				merged_line[b*8 +: 8] = rd_req.data[b*8 +: 8];
			else
				merged_line[b*8 +: 8] = old_line[b*8 +: 8];
		end
	end

	assign is_store = rd_req.op == OP_STORE || rd_req.op == OP_STORE_SYNC;
	assign line_present = rd_hit || rd_req.has_sm_data;

	always_comb
	begin
		update.valid = 1'b0;
		update.way = 8'(rd_way);
		update.set = 8'(rd_req.address[SET_BITS-1:0]);
		update.tag = rd_req.address;
		update.data = merged_line;
		if (rd_req.valid)
		begin
			if (rd_req.op == OP_STORE_SYNC)
				update.valid = line_present && rd_sync_success;
			else if (rd_req.op == OP_STORE)
				update.valid = line_present;
			else if (rd_req.has_sm_data)
			begin
				// Load restart, so the fetched line gets filled.
				update.valid = 1'b1;
				update.data = rd_req.sm_data;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resp.valid <= 1'b0;
		end
		else if (!stall_pipeline)
		begin
			resp.valid <= rd_req.valid;
			resp.unit <= rd_req.unit;
			resp.strand <= rd_req.strand;
			resp.op <= rd_req.op;
			resp.address <= rd_req.address;
			resp.data <= is_store ? merged_line : old_line;
			resp.hit <= line_present;
			resp.sync_success <= rd_sync_success;
		end
	end
endmodule

`default_nettype wire

//--- rtl/l2_cache.sv
// L2 cache top: tag, read and write stages around a generate loop of ways.
`default_nettype none

module l2_cache #(
	parameter int NUM_WAYS = 4,
	parameter int NUM_SETS = 16
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_req_t req,
	output l2_cache_pkg::l2_resp_t resp
);
	import l2_cache_pkg::*;

	localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	l2_req_t tag_req;
	l2_req_t rd_req;
	wire l2_lookup_t [NUM_WAYS-1:0] lookup;
	l2_update_t update;
	logic [LINE_BITS-1:0] rd_old_data;
	logic rd_hit;
	logic [WAY_BITS-1:0] rd_way;
	logic rd_sync_success;

	l2_cache_tag i_tag (
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.req(req),
		.tag_req(tag_req)
	);

	// Identical ways, each picking its own updates by index.
	for (genvar i = 0; i < NUM_WAYS; i++)
	begin : g_way
		l2_cache_way #(
			.NUM_SETS(NUM_SETS),
			.WAY_ID(i)
		) i_way (
			.clk(clk),
			.rst(rst),
			.stall_pipeline(stall_pipeline),
			.tag_req(tag_req),
			.update(update),
			.lookup(lookup[i])
		);
	end

	l2_cache_read #(
		.NUM_WAYS(NUM_WAYS),
		.NUM_SETS(NUM_SETS)
	) i_read (
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.tag_req(tag_req),
		.lookup(lookup),
		.update(update),
		.rd_req(rd_req),
		.rd_old_data(rd_old_data),
		.rd_hit(rd_hit),
		.rd_way(rd_way),
		.rd_sync_success(rd_sync_success)
	);

	l2_cache_write #(
		.NUM_WAYS(NUM_WAYS),
		.NUM_SETS(NUM_SETS)
	) i_write (
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.rd_req(rd_req),
		.rd_old_data(rd_old_data),
		.rd_hit(rd_hit),
		.rd_way(rd_way),
		.rd_sync_success(rd_sync_success),
		.update(update),
		.resp(resp)
	);
endmodule

`default_nettype wire

//--- tb/l2_cache_chk.sv
// Concurrent checks on the L2 cache response port, bound into the top level.
`default_nettype none

module l2_cache_chk (
	input wire logic clk,
	input wire logic rst,
	input wire logic stall_pipeline,
	input wire l2_cache_pkg::l2_resp_t resp
);
	// A reset edge leaves no response behind.
	resp_idle_in_reset: assert property (@(posedge clk) rst |=> !resp.valid)
		else $error("response valid after a reset edge");

	// A stalled edge must not move the response register.
	resp_hold_in_stall: assert property (
		@(posedge clk) disable iff (rst)
		stall_pipeline |=> $stable(resp)
	)
		else $error("response changed during a stall");
endmodule

bind l2_cache l2_cache_chk i_l2_cache_chk (
	.clk(clk),
	.rst(rst),
	.stall_pipeline(stall_pipeline),
	.resp(resp)
);

`default_nettype wire

//--- tb/l2_cache_tb.sv
// Directed testbench for the L2 cache with clock, reset, memory and cache model, tests and watchdog.
`default_nettype none

module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 5;
	localparam logic [31:0] SEED = 32'hb40e_7a3b;
	localparam int STALL_REQUESTS = 24;
	// Requests of the directed tests, the fill of LINE_C included.
	localparam int FIXED_REQUESTS = 26;
	localparam int WATCHDOG_CYCLES = 40 * (FIXED_REQUESTS + STALL_REQUESTS) + RESET_CYCLES;
	localparam logic [ADDR_WIDTH-1:0] LINE_A = 26'h00a_bc3;
	localparam logic [ADDR_WIDTH-1:0] LINE_B = 26'h01f_0e7;
	localparam logic [ADDR_WIDTH-1:0] LINE_C = 26'h002_2a1;
	localparam logic [LINE_BYTES-1:0] FULL_MASK = '1;

	logic clk;
	logic rst;
	logic stall_pipeline;
	l2_req_t req;
	l2_resp_t resp;

	// System memory and the expected cache state.
	logic [31:0] lcg_state = SEED;
	logic [LINE_BITS-1:0] memory [logic [ADDR_WIDTH-1:0]];
	logic cache_valid [NUM_SETS][NUM_WAYS];
	logic [ADDR_WIDTH-1:0] cache_tag [NUM_SETS][NUM_WAYS];
	logic [LINE_BITS-1:0] cache_data [NUM_SETS][NUM_WAYS];
	int rr_next [NUM_SETS];
	logic link_valid [4];
	logic [ADDR_WIDTH-1:0] link_addr [4];

	// Expected responses with the unstalled edge each is due after.
	l2_resp_t exp_q [$];
	int due_q [$];
	int edge_count = 0;
	logic fresh = 1'b0;
	l2_resp_t mon_expected;

	l2_cache #(
		.NUM_WAYS(NUM_WAYS),
		.NUM_SETS(NUM_SETS)
	) i_l2_cache (
		.clk(clk),
		.rst(rst),
		.stall_pipeline(stall_pipeline),
		.req(req),
		.resp(resp)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [LINE_BITS-1:0] random_line();
		return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
	endfunction

	// Memory contents appear on first touch.
	function automatic logic [LINE_BITS-1:0] memory_line(input logic [ADDR_WIDTH-1:0] address);
		if (!memory.exists(address))
			memory[address] = random_line();
		return memory[address];
	endfunction

	function automatic logic [LINE_BITS-1:0] merge_bytes(input logic [LINE_BITS-1:0] line,
		input logic [LINE_BITS-1:0] data, input logic [LINE_BYTES-1:0] mask);
		logic [LINE_BITS-1:0] result;
		result = line;
		for (int b = 0; b < LINE_BYTES; b++)
		begin
			if (mask[b])
				result[b*8 +: 8] = data[b*8 +: 8];
		end
		return result;
	endfunction

	function automatic void clear_model();
		for (int s = 0; s < NUM_SETS; s++)
		begin
			rr_next[s] = 0;
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				cache_valid[s][w] = 1'b0;
				cache_tag[s][w] = '0;
				cache_data[s][w] = '0;
			end
		end
		for (int i = 0; i < 4; i++)
		begin
			link_valid[i] = 1'b0;
			link_addr[i] = '0;
		end
	endfunction

	function automatic l2_req_t make_req(input l2_op_t op, input logic [1:0] strand,
		input logic [ADDR_WIDTH-1:0] address, input logic [LINE_BITS-1:0] data,
		input logic [LINE_BYTES-1:0] mask, input logic has_sm_data);
		l2_req_t r;
		r = '0;
		r.valid = 1'b1;
		// Unit differs from strand so that a swap shows up.
		r.unit = ~strand;
		r.strand = strand;
		r.op = op;
		r.address = address;
		r.data = data;
		r.mask = mask;
		r.has_sm_data = has_sm_data;
		if (has_sm_data)
			r.sm_data = memory_line(address);
		return r;
	endfunction

	// Applies one request to the cache model in program order and returns its response.
	function automatic l2_resp_t predict(input l2_req_t r);
		l2_resp_t p;
		logic [SET_BITS-1:0] index;
		logic hit;
		int way;
		logic [LINE_BITS-1:0] base;
		logic [LINE_BITS-1:0] merged;
		logic sync_ok;
		logic is_store;
		logic present;
		logic commit;
		index = r.address[SET_BITS-1:0];
		hit = 1'b0;
		way = rr_next[index];
		base = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (cache_valid[index][w] && cache_tag[index][w] == r.address)
			begin
				hit = 1'b1;
				way = w;
				base = cache_data[index][w];
			end
		end
		sync_ok = r.op == OP_STORE_SYNC && link_valid[r.strand] && link_addr[r.strand] == r.address;
		is_store = r.op == OP_STORE || r.op == OP_STORE_SYNC;
		present = hit || r.has_sm_data;
		commit = present && (r.op == OP_STORE || sync_ok);
		if (r.has_sm_data)
			base = r.sm_data;
		merged = merge_bytes(base, r.data, r.mask);
		if (commit || (!is_store && r.has_sm_data))
		begin
			cache_valid[index][way] = 1'b1;
			cache_tag[index][way] = r.address;
			cache_data[index][way] = is_store ? merged : r.sm_data;
		end
		// A fill that missed moves the set's victim pointer on.
		if (r.has_sm_data && !hit)
			rr_next[index] = (rr_next[index] + 1) % NUM_WAYS;
		for (int s = 0; s < 4; s++)
		begin
			if (commit && link_addr[s] == r.address)
				link_valid[s] = 1'b0;
		end
		if (r.op == OP_LOAD_SYNC)
		begin
			link_valid[r.strand] = 1'b1;
			link_addr[r.strand] = r.address;
		end
		p = '0;
		p.valid = 1'b1;
		p.unit = r.unit;
		p.strand = r.strand;
		p.op = r.op;
		p.address = r.address;
		p.data = is_store ? merged : base;
		p.hit = present;
		p.sync_success = sync_ok;
		return p;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic step();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Holds the request through a stall, then lets one edge take it.
	task automatic send(input l2_req_t r, input int stall_cycles, output l2_resp_t predicted);
		req = r;
		for (int i = 0; i < stall_cycles; i++)
		begin
			stall_pipeline = 1'b1;
			step();
		end
		stall_pipeline = 1'b0;
		step();
		predicted = predict(r);
		exp_q.push_back(predicted);
		due_q.push_back(edge_count + 2);
		req = '0;
	endtask

	task automatic idle(input int cycles, input logic with_stall);
		req = '0;
		for (int i = 0; i < cycles; i++)
		begin
			stall_pipeline = with_stall & 1'(lcg_next() >> 31);
			step();
		end
		stall_pipeline = 1'b0;
	endtask

	task automatic drain();
		req = '0;
		stall_pipeline = 1'b0;
		while (exp_q.size() != 0)
			step();
	endtask

	task automatic check_resp(input l2_resp_t expected);
		assert (resp.valid)
			else report_error($sformatf("no response for line %h", expected.address));
		assert (resp.address == expected.address && resp.op == expected.op
			&& resp.unit == expected.unit && resp.strand == expected.strand)
			else report_error($sformatf("response line %h op %0d, expected line %h op %0d",
				resp.address, resp.op, expected.address, expected.op));
		assert (resp.hit == expected.hit)
			else report_error($sformatf("line %h hit %b, expected %b",
				expected.address, resp.hit, expected.hit));
		assert (resp.data == expected.data)
			else report_error($sformatf("line %h data %h, expected %h",
				expected.address, resp.data, expected.data));
		assert (resp.sync_success == expected.sync_success)
			else report_error($sformatf("line %h sync_success %b, expected %b",
				expected.address, resp.sync_success, expected.sync_success));
	endtask

	// Count unstalled edges; resp only changes on those.
	always @(posedge clk)
	begin
		fresh <= !rst && !stall_pipeline;
		if (!rst && !stall_pipeline)
			edge_count <= edge_count + 1;
	end

	always @(negedge clk)
	begin
		if (fresh)
		begin
			if (due_q.size() != 0 && due_q[0] == edge_count)
			begin
				mon_expected = exp_q.pop_front();
				due_q.delete(0);
				check_resp(mon_expected);
			end
			else
			begin
				assert (!resp.valid) else report_error("response appeared with no request due");
			end
		end
	end

	task automatic miss_then_fill();
		l2_resp_t p1;
		l2_resp_t p2;
		l2_resp_t p3;
		send(make_req(OP_LOAD, 2'd0, LINE_A, '0, '0, 1'b0), 0, p1);
		send(make_req(OP_LOAD, 2'd0, LINE_A, '0, '0, 1'b1), 0, p2);
		send(make_req(OP_LOAD, 2'd0, LINE_A, '0, '0, 1'b0), 0, p3);
		drain();
		assert (!p1.hit && p2.hit && p3.hit) else report_error("miss and fill gave wrong hit flags");
		assert (p2.data == memory_line(LINE_A) && p3.data == p2.data)
			else report_error("filled line differs from memory");
	endtask

	task automatic store_merge();
		l2_resp_t p1;
		l2_resp_t p2;
		logic [LINE_BITS-1:0] data;
		logic [LINE_BYTES-1:0] mask;
		data = random_line();
		mask = 16'(lcg_next());
		send(make_req(OP_STORE, 2'd1, LINE_A, data, mask, 1'b0), 0, p1);
		idle(2, 1'b0);
		send(make_req(OP_LOAD, 2'd0, LINE_A, '0, '0, 1'b0), 0, p2);
		drain();
		assert (p1.hit && p1.data == merge_bytes(memory_line(LINE_A), data, mask))
			else report_error("store merge expectation is wrong");
		assert (p2.data == p1.data) else report_error("load after store lost the merge");
	endtask

	task automatic forward_back_to_back();
		l2_resp_t p1;
		l2_resp_t p2;
		send(make_req(OP_STORE, 2'd2, LINE_A, random_line(), 16'(lcg_next()), 1'b0), 0, p1);
		send(make_req(OP_LOAD, 2'd0, LINE_A, '0, '0, 1'b0), 0, p2);
		drain();
		assert (p2.hit && p2.data == p1.data) else report_error("load did not see the store");
	endtask

	task automatic sync_store();
		l2_resp_t p_fill;
		l2_resp_t p_link;
		l2_resp_t p_ok;
		l2_resp_t p_store;
		l2_resp_t p_fail;
		l2_resp_t p_load;
		send(make_req(OP_LOAD, 2'd0, LINE_B, '0, '0, 1'b1), 0, p_fill);
		send(make_req(OP_LOAD_SYNC, 2'd1, LINE_B, '0, '0, 1'b0), 0, p_link);
		send(make_req(OP_STORE_SYNC, 2'd1, LINE_B, random_line(), FULL_MASK, 1'b0), 0, p_ok);
		send(make_req(OP_LOAD_SYNC, 2'd1, LINE_B, '0, '0, 1'b0), 0, p_link);
		// A plain load by the linked strand reports no success.
		send(make_req(OP_LOAD, 2'd1, LINE_B, '0, '0, 1'b0), 0, p_link);
		send(make_req(OP_STORE, 2'd2, LINE_B, random_line(), 16'(lcg_next()), 1'b0), 0, p_store);
		send(make_req(OP_STORE_SYNC, 2'd1, LINE_B, random_line(), FULL_MASK, 1'b0), 0, p_fail);
		send(make_req(OP_LOAD, 2'd0, LINE_B, '0, '0, 1'b0), 0, p_load);
		drain();
		assert (p_ok.hit && p_ok.sync_success) else report_error("linked store-sync did not succeed");
		assert (!p_fail.sync_success) else report_error("store-sync after a foreign store succeeded");
		assert (p_load.data == p_store.data) else report_error("failed store-sync changed the line");
	endtask

	task automatic replacement();
		l2_resp_t p;
		logic [ADDR_WIDTH-1:0] line;
		// Distinct tags in set 9, which no other test uses.
		for (int t = 0; t <= NUM_WAYS; t++)
		begin
			line = ADDR_WIDTH'((t + 1) * NUM_SETS + 9);
			send(make_req(OP_LOAD, 2'd3, line, '0, '0, 1'b1), 0, p);
		end
		for (int t = 0; t <= NUM_WAYS; t++)
		begin
			line = ADDR_WIDTH'((t + 1) * NUM_SETS + 9);
			send(make_req(OP_LOAD, 2'd3, line, '0, '0, 1'b0), 0, p);
			assert ((t == 0) != p.hit) else report_error("wrong line was evicted");
		end
		drain();
	endtask

	task automatic random_stall();
		l2_resp_t p;
		l2_req_t r;
		logic [ADDR_WIDTH-1:0] line;
		int pick;
		send(make_req(OP_LOAD, 2'd0, LINE_C, '0, '0, 1'b1), 0, p);
		for (int i = 0; i < STALL_REQUESTS; i++)
		begin
			pick = int'(lcg_next() % 32'd3);
			line = (pick == 0) ? LINE_A : ((pick == 1) ? LINE_B : LINE_C);
			if (lcg_next() % 32'd2 == 32'd0)
				r = make_req(OP_LOAD, 2'(i), line, '0, '0, 1'b0);
			else
				r = make_req(OP_STORE, 2'(i), line, random_line(), 16'(lcg_next()), 1'b0);
			send(r, int'(lcg_next() % 32'd4), p);
			idle(int'(lcg_next() % 32'd3), 1'b1);
		end
		drain();
	endtask

	initial
	begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1, "simulation timeout");
	end

	initial
	begin
		rst = 1'b1;
		stall_pipeline = 1'b0;
		req = '0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		miss_then_fill();
		store_merge();
		forward_back_to_back();
		sync_store();
		replacement();
		random_stall();
		$display("All tests passed");
		$finish;
	end
endmodule

`default_nettype wire

//--- l2_cache.f
rtl/l2_cache_pkg.sv
rtl/l2_cache_tag.sv
rtl/l2_cache_way.sv
rtl/l2_cache_read.sv
rtl/l2_cache_write.sv
rtl/l2_cache.sv
tb/l2_cache_chk.sv
tb/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	-f l2_cache.f \
	--top-module l2_cache_tb \
	-o l2_cache_sim
./obj_dir/l2_cache_sim
